// ==== common/hqm_reset_pkg.sv ====
package hqm_reset_pkg;

  // Synchronized reset copies per clock domain
  localparam int unsigned HQM_NUM_GATED     = 2;
  localparam int unsigned HQM_NUM_INP_GATED = 1;
  localparam int unsigned HQM_NUM_PGSB      = 2;

  // Delay stages between the captured release edge and the start level.
  // With the trigger and sticky stages this puts start on edge 5 after release
  localparam int unsigned HQM_START_DELAY = 3;

  // PF state memory sweep
  localparam int unsigned HQM_PF_INIT_ENTRIES = 16;
  localparam int unsigned HQM_PF_ADDR_W       = 4;

  // PF reset sequencer states
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    SWEEP      = 2'd1,
    DONE_PULSE = 2'd2,
    DONE       = 2'd3
  } pf_seq_state_t;

endpackage

// ==== src/hqm_reset_sync_scan.sv ====
module hqm_reset_sync_scan (
    input  logic clk
  , input  logic rst_n
  , input  logic fscan_rstbypen
  , input  logic fscan_byprst_b
  , output logic rst_n_sync
);

  logic sync0_f;
  logic sync1_f;

  // Assert asynchronously, release through two flops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync0_f <= 1'b0;
      sync1_f <= 1'b0;
    end else begin
      sync0_f <= 1'b1;
      sync1_f <= sync0_f;
    end
  end

  // Scan mode drives the reset straight from the tester
  assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync1_f;

endmodule

// ==== reset_core/hqm_reset_start_gen.sv ====
module hqm_reset_start_gen (
    input  logic clk
  , input  logic rst_n
  , output logic start
);

  import hqm_reset_pkg::*;

  logic                       trigger0_f;
  logic                       trigger1_f;
  logic                       start0_f;
  logic [HQM_START_DELAY-1:0] delay_f;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trigger0_f <= 1'b0;
      trigger1_f <= 1'b0;
      start0_f   <= 1'b0;
      delay_f    <= '0;
    end else begin
      trigger0_f <= 1'b1;
      trigger1_f <= trigger0_f;
      // Sticky once the first cycle out of reset is seen
      start0_f   <= (trigger0_f & ~trigger1_f) | start0_f;
      delay_f[0] <= start0_f;
      for (int i = 1; i < HQM_START_DELAY; i++) begin
        delay_f[i] <= delay_f[i-1];
      end
    end
  end

  // Held back so downstream clocks have settled
  assign start = delay_f[HQM_START_DELAY-1];

endmodule

// ==== reset_core/hqm_reset_core.sv ====
module hqm_reset_core #(
    parameter int unsigned HQM_NUM_GATED     = hqm_reset_pkg::HQM_NUM_GATED
  , parameter int unsigned HQM_NUM_INP_GATED = hqm_reset_pkg::HQM_NUM_INP_GATED
  , parameter int unsigned HQM_NUM_PGSB      = hqm_reset_pkg::HQM_NUM_PGSB
) (
    input  logic                         fscan_rstbypen
  , input  logic                         fscan_byprst_b

  , input  logic                         hqm_pgcb_clk
  , output logic [HQM_NUM_PGSB-1:0]      hqm_pgcb_rst_n
  , output logic                         hqm_pgcb_rst_n_start

  , input  logic                         hqm_inp_gated_clk
  , output logic [HQM_NUM_INP_GATED-1:0] hqm_inp_gated_rst_n

  , input  logic                         hqm_gated_clk
  , input  logic                         hqm_gated_rst_b
  , output logic [HQM_NUM_GATED-1:0]     hqm_gated_rst_n
  , output logic                         hqm_gated_rst_n_start
  , output logic                         hqm_gated_rst_n_active
  , input  logic                         hqm_gated_rst_n_done

  , input  logic                         hqm_flr_prep
  , output logic                         rst_prep
);

  logic hqm_gated_rst_n_active_f;

  assign rst_prep = hqm_flr_prep;

  // One raw reset feeds every domain
  for (genvar g = 0; g < HQM_NUM_PGSB; g++) begin : g_pgcb
    hqm_reset_sync_scan i_sync (
        .clk            (hqm_pgcb_clk)
      , .rst_n          (hqm_gated_rst_b)
      , .fscan_rstbypen (fscan_rstbypen)
      , .fscan_byprst_b (fscan_byprst_b)
      , .rst_n_sync     (hqm_pgcb_rst_n[g])
    );
  end

  // Copy 0 also resets the active flop below
  for (genvar g = 0; g < HQM_NUM_INP_GATED; g++) begin : g_inp_gated
    hqm_reset_sync_scan i_sync (
        .clk            (hqm_inp_gated_clk)
      , .rst_n          (hqm_gated_rst_b)
      , .fscan_rstbypen (fscan_rstbypen)
      , .fscan_byprst_b (fscan_byprst_b)
      , .rst_n_sync     (hqm_inp_gated_rst_n[g])
    );
  end

  for (genvar g = 0; g < HQM_NUM_GATED; g++) begin : g_gated
    hqm_reset_sync_scan i_sync (
        .clk            (hqm_gated_clk)
      , .rst_n          (hqm_gated_rst_b)
      , .fscan_rstbypen (fscan_rstbypen)
      , .fscan_byprst_b (fscan_byprst_b)
      , .rst_n_sync     (hqm_gated_rst_n[g])
    );
  end

  // Active from reset until the PF sequencer reports done.
  // Runs on the free clock so the local clock can be kept on by it
  always_ff @(posedge hqm_inp_gated_clk or negedge hqm_inp_gated_rst_n[0]) begin
    if (!hqm_inp_gated_rst_n[0]) begin
      hqm_gated_rst_n_active_f <= 1'b1;
    end else begin
      hqm_gated_rst_n_active_f <= hqm_gated_rst_n_active_f & ~hqm_gated_rst_n_done;
    end
  end

  assign hqm_gated_rst_n_active = hqm_gated_rst_n_active_f;

  // Start level for the PF sequencer
  hqm_reset_start_gen i_gated_start (
      .clk   (hqm_gated_clk)
    , .rst_n (hqm_gated_rst_n[0])
    , .start (hqm_gated_rst_n_start)
  );

  hqm_reset_start_gen i_pgcb_start (
      .clk   (hqm_pgcb_clk)
    , .rst_n (hqm_pgcb_rst_n[0])
    , .start (hqm_pgcb_rst_n_start)
  );

endmodule

// ==== pf_reset/hqm_pf_reset_seq.sv ====
module hqm_pf_reset_seq (
    input  logic                                   hqm_gated_clk
  , input  logic                                   hqm_gated_rst_n
  , input  logic                                   start
  , output logic                                   init_we
  , output logic [hqm_reset_pkg::HQM_PF_ADDR_W-1:0] init_addr
  , output logic                                   done
);

  import hqm_reset_pkg::*;

  pf_seq_state_t             state_f;
  pf_seq_state_t             state_nxt;
  logic [HQM_PF_ADDR_W-1:0] addr_f;
  logic [HQM_PF_ADDR_W-1:0] addr_nxt;
  logic                      last_entry;

  assign last_entry = (addr_f == HQM_PF_ADDR_W'(HQM_PF_INIT_ENTRIES - 1));

  always_comb begin
    state_nxt = state_f;
    addr_nxt  = addr_f;
    case (state_f)
      IDLE: begin
        if (start) begin
          state_nxt = SWEEP;
          addr_nxt  = '0;
        end
      end
      SWEEP: begin
        // One entry per cycle
        if (last_entry) begin
          state_nxt = DONE_PULSE;
        end else begin
          addr_nxt = addr_f + 1'b1;
        end
      end
      DONE_PULSE: state_nxt = DONE;
      // Stays here until the next reset
      DONE:       state_nxt = DONE;
      default:    state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_n) begin
    if (!hqm_gated_rst_n) begin
      state_f <= IDLE;
      addr_f  <= '0;
    end else begin
      state_f <= state_nxt;
      addr_f  <= addr_nxt;
    end
  end

  assign init_we   = (state_f == SWEEP);
  assign init_addr = addr_f;
  assign done      = (state_f == DONE_PULSE);

endmodule

// ==== src/hqm_clk_gate.sv ====
module hqm_clk_gate (
    input  logic clk
  , input  logic en
  , output logic gclk
);

  logic en_lat;

  // Enable can only change while clk is low, so gclk has no glitches
  always_latch begin
    if (!clk) begin
      en_lat = en;
    end
  end

  assign gclk = clk & en_lat;

endmodule

// ==== src/hqm_reset_top.sv ====
module hqm_reset_top (
    input  logic                                   hqm_gated_clk
  , input  logic                                   hqm_pgcb_clk
  , input  logic                                   hqm_gated_rst_n
  , input  logic                                   fscan_rstbypen
  , input  logic                                   fscan_byprst_b
  , input  logic                                   func_clk_en
  , input  logic                                   hqm_flr_prep
  , output logic [hqm_reset_pkg::HQM_NUM_GATED-1:0] hqm_gated_rst_n_sync
  , output logic [hqm_reset_pkg::HQM_NUM_PGSB-1:0]  hqm_pgcb_rst_n
  , output logic                                   hqm_pgcb_rst_n_start
  , output logic                                   hqm_gated_rst_n_active
  , output logic                                   pf_init_we
  , output logic [hqm_reset_pkg::HQM_PF_ADDR_W-1:0] pf_init_addr
  , output logic                                   pf_reset_done
  , output logic                                   rst_prep
);

  import hqm_reset_pkg::*;

  logic                         hqm_gated_local_clk;
  logic                         local_clk_en;
  logic                         hqm_gated_rst_n_start;
  logic [HQM_NUM_INP_GATED-1:0] hqm_inp_gated_rst_n;

  // Local clock runs through reset and the PF sweep
  assign local_clk_en = hqm_gated_rst_n_active | func_clk_en;

  hqm_reset_core #(
      .HQM_NUM_GATED     (HQM_NUM_GATED)
    , .HQM_NUM_INP_GATED (HQM_NUM_INP_GATED)
    , .HQM_NUM_PGSB      (HQM_NUM_PGSB)
  ) i_core (
      .fscan_rstbypen         (fscan_rstbypen)
    , .fscan_byprst_b         (fscan_byprst_b)
    , .hqm_pgcb_clk           (hqm_pgcb_clk)
    , .hqm_pgcb_rst_n         (hqm_pgcb_rst_n)
    , .hqm_pgcb_rst_n_start   (hqm_pgcb_rst_n_start)
    , .hqm_inp_gated_clk      (hqm_gated_clk)
    , .hqm_inp_gated_rst_n    (hqm_inp_gated_rst_n)
    , .hqm_gated_clk          (hqm_gated_local_clk)
    , .hqm_gated_rst_b        (hqm_gated_rst_n)
    , .hqm_gated_rst_n        (hqm_gated_rst_n_sync)
    , .hqm_gated_rst_n_start  (hqm_gated_rst_n_start)
    , .hqm_gated_rst_n_active (hqm_gated_rst_n_active)
    , .hqm_gated_rst_n_done   (pf_reset_done)
    , .hqm_flr_prep           (hqm_flr_prep)
    , .rst_prep               (rst_prep)
  );

  hqm_clk_gate i_clk_gate (
      .clk  (hqm_gated_clk)
    , .en   (local_clk_en)
    , .gclk (hqm_gated_local_clk)
  );

  hqm_pf_reset_seq i_pf_seq (
      .hqm_gated_clk   (hqm_gated_local_clk)
    , .hqm_gated_rst_n (hqm_gated_rst_n_sync[0])
    , .start           (hqm_gated_rst_n_start)
    , .init_we         (pf_init_we)
    , .init_addr       (pf_init_addr)
    , .done            (pf_reset_done)
  );

endmodule

// ==== verif/tb_hqm_reset_top.sv ====
module tb_hqm_reset_top;

  timeunit 1ns;
  timeprecision 1ps;

  import hqm_reset_pkg::*;

  typedef struct packed {
    logic       bypen;
    logic       byprst_b;
    logic       clk_en;
    logic       flr_prep;
    logic       mid_pulse;
    logic [3:0] pulse_cycles;
    logic       exp_prep;
    logic       exp_byp;
  } row_t;

  localparam int NUM_ROWS    = 5;
  localparam int RST_CYCLES  = 5;
  localparam int CYCLE_LIMIT = NUM_ROWS * 60 + 100;

  logic                     hqm_gated_clk;
  logic                     hqm_pgcb_clk;
  logic                     hqm_gated_rst_n;
  logic                     fscan_rstbypen;
  logic                     fscan_byprst_b;
  logic                     func_clk_en;
  logic                     hqm_flr_prep;
  logic [HQM_NUM_GATED-1:0] hqm_gated_rst_n_sync;
  logic [HQM_NUM_PGSB-1:0]  hqm_pgcb_rst_n;
  logic                     hqm_pgcb_rst_n_start;
  logic                     hqm_gated_rst_n_active;
  logic                     pf_init_we;
  logic [HQM_PF_ADDR_W-1:0] pf_init_addr;
  logic                     pf_reset_done;
  logic                     rst_prep;

  row_t                     rows [NUM_ROWS];
  logic [HQM_PF_ADDR_W-1:0] wr_q [$];
  int                       done_count;
  int                       errors;
  int                       checks;
  int                       cycles;
  int                       release_cycle;
  integer                   seed;

  hqm_reset_top uut (
      .hqm_gated_clk          (hqm_gated_clk)
    , .hqm_pgcb_clk           (hqm_pgcb_clk)
    , .hqm_gated_rst_n        (hqm_gated_rst_n)
    , .fscan_rstbypen         (fscan_rstbypen)
    , .fscan_byprst_b         (fscan_byprst_b)
    , .func_clk_en            (func_clk_en)
    , .hqm_flr_prep           (hqm_flr_prep)
    , .hqm_gated_rst_n_sync   (hqm_gated_rst_n_sync)
    , .hqm_pgcb_rst_n         (hqm_pgcb_rst_n)
    , .hqm_pgcb_rst_n_start   (hqm_pgcb_rst_n_start)
    , .hqm_gated_rst_n_active (hqm_gated_rst_n_active)
    , .pf_init_we             (pf_init_we)
    , .pf_init_addr           (pf_init_addr)
    , .pf_reset_done          (pf_reset_done)
    , .rst_prep               (rst_prep)
  );

  initial begin
    hqm_gated_clk = 1'b0;
    forever #5 hqm_gated_clk = ~hqm_gated_clk;
  end

  // pgcb clock runs 3 ns behind the free clock
  initial begin
    hqm_pgcb_clk = 1'b0;
    #3;
    forever #5 hqm_pgcb_clk = ~hqm_pgcb_clk;
  end

  // Sampled on the falling edge, away from both clock edges
  always @(negedge hqm_gated_clk) begin
    if (pf_init_we === 1'b1) begin
      wr_q.push_back(pf_init_addr);
    end
    if (pf_reset_done === 1'b1) begin
      done_count++;
    end
  end

  always @(posedge hqm_gated_clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks: %0d  Errors: %0d", checks, errors);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic row_t make_row(input logic bypen, input logic byprst_b,
                                    input logic clk_en, input logic flr_prep,
                                    input logic mid_pulse, input logic [3:0] pulse_cycles,
                                    input logic exp_prep, input logic exp_byp);
    row_t r;
    r.bypen        = bypen;
    r.byprst_b     = byprst_b;
    r.clk_en       = clk_en;
    r.flr_prep     = flr_prep;
    r.mid_pulse    = mid_pulse;
    r.pulse_cycles = pulse_cycles;
    r.exp_prep     = exp_prep;
    r.exp_byp      = exp_byp;
    return r;
  endfunction

  task automatic drive_slot();
    @(posedge hqm_gated_clk);
    #1;
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Error %0t: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  task automatic check_in_reset();
    check_value("active in reset", hqm_gated_rst_n_active, 1);
    check_value("pf_init_we in reset", pf_init_we, 0);
    check_value("pf_reset_done in reset", pf_reset_done, 0);
    check_value("pgcb start in reset", hqm_pgcb_rst_n_start, 0);
    check_value("gated resets in reset", hqm_gated_rst_n_sync, 0);
    check_value("pgcb resets in reset", hqm_pgcb_rst_n, 0);
  endtask

  // Called in a drive slot, returns at the falling edge after release
  task automatic hold_reset(input int n);
    hqm_gated_rst_n = 1'b0;
    repeat (n) begin
      @(negedge hqm_gated_clk);
      check_in_reset();
    end
    drive_slot();
    hqm_gated_rst_n = 1'b1;
    wr_q.delete();
    done_count    = 0;
    release_cycle = cycles;
    @(negedge hqm_gated_clk);
    check_in_reset();
  endtask

  task automatic wait_released();
    int n;
    n = 0;
    while (n < 10 && !(&hqm_gated_rst_n_sync && &hqm_pgcb_rst_n && hqm_pgcb_rst_n_start)) begin
      @(negedge hqm_gated_clk);
      n++;
    end
    checks++;
    assert (&hqm_gated_rst_n_sync && &hqm_pgcb_rst_n && hqm_pgcb_rst_n_start) else begin
      errors++;
      $display("Error %0t: resets or pgcb start not released within 10 cycles", $time);
    end
  endtask

  task automatic wait_writes(input int k);
    int n;
    n = 0;
    while (n < 30 && wr_q.size() < k) begin
      @(negedge hqm_gated_clk);
      n++;
    end
    checks++;
    assert (wr_q.size() >= k) else begin
      errors++;
      $display("Error %0t: only %0d of %0d init writes seen", $time, wr_q.size(), k);
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (n < 30 && done_count == 0) begin
      @(negedge hqm_gated_clk);
      n++;
    end
    checks++;
    assert (done_count > 0 && cycles - release_cycle <= 30) else begin
      errors++;
      $display("Error %0t: pf_reset_done not seen within 30 cycles of release", $time);
    end
  endtask

  // Model of the sweep is every entry once, in address order
  task automatic check_sweep();
    check_value("init write count", wr_q.size(), HQM_PF_INIT_ENTRIES);
    for (int k = 0; k < wr_q.size(); k++) begin
      check_value("init address", wr_q[k], k);
    end
    check_value("done strobes", done_count, 1);
  endtask

  task automatic check_after_done();
    repeat (8) begin
      @(negedge hqm_gated_clk);
      check_value("active after done", hqm_gated_rst_n_active, 0);
      check_value("pgcb start held", hqm_pgcb_rst_n_start, 1);
    end
    check_value("init writes after done", wr_q.size(), HQM_PF_INIT_ENTRIES);
    check_value("done strobes after done", done_count, 1);
  endtask

  task automatic run_row(input row_t r);
    drive_slot();
    hqm_flr_prep   = r.flr_prep;
    func_clk_en    = r.clk_en;
    fscan_rstbypen = r.bypen;
    fscan_byprst_b = r.byprst_b;
    // Synchronizers held at the opposite level of the bypass value
    if (r.bypen) begin
      hqm_gated_rst_n = ~r.byprst_b;
    end
    // No clock edge before this point
    #1;
    check_value("rst_prep", rst_prep, r.exp_prep);
    if (r.bypen) begin
      check_value("gated resets in bypass", hqm_gated_rst_n_sync, {HQM_NUM_GATED{r.exp_byp}});
      check_value("pgcb resets in bypass", hqm_pgcb_rst_n, {HQM_NUM_PGSB{r.exp_byp}});
    end
    drive_slot();
    fscan_rstbypen = 1'b0;
    hold_reset(RST_CYCLES);
    wait_released();
    if (r.mid_pulse) begin
      wait_writes(6);
      drive_slot();
      hold_reset(r.pulse_cycles);
      wait_released();
    end
    wait_done();
    check_sweep();
    check_after_done();
    check_value("rst_prep after run", rst_prep, r.exp_prep);
    // Idle gap with a random clock enable
    drive_slot();
    func_clk_en = (($random(seed) & 1) != 0);
    repeat (4) begin
      @(negedge hqm_gated_clk);
      check_value("init write between runs", pf_init_we, 0);
    end
  endtask

  initial begin
    seed            = 32'h19eee89b;
    errors          = 0;
    checks          = 0;
    cycles          = 0;
    done_count      = 0;
    release_cycle   = 0;
    hqm_gated_rst_n = 1'b0;
    fscan_rstbypen  = 1'b0;
    fscan_byprst_b  = 1'b0;
    func_clk_en     = 1'b0;
    hqm_flr_prep    = 1'b0;

    // bypen byprst_b clk_en flr_prep mid_pulse pulse_cycles exp_prep exp_byp
    rows[0] = make_row(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0, 1'b0, 1'b0);
    rows[1] = make_row(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 4'd0, 1'b1, 1'b0);
    rows[2] = make_row(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 4'd2, 1'b0, 1'b0);
    rows[3] = make_row(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 4'd0, 1'b1, 1'b0);
    rows[4] = make_row(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 4'd3, 1'b0, 1'b1);

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
common/hqm_reset_pkg.sv
src/hqm_reset_sync_scan.sv
reset_core/hqm_reset_start_gen.sv
reset_core/hqm_reset_core.sv
pf_reset/hqm_pf_reset_seq.sv
src/hqm_clk_gate.sv
src/hqm_reset_top.sv
verif/tb_hqm_reset_top.sv

// ==== Bender.yml ====
package:
  name: hqm_reset

sources:
  - files:
      - common/hqm_reset_pkg.sv
      - src/hqm_reset_sync_scan.sv
      - reset_core/hqm_reset_start_gen.sv
      - reset_core/hqm_reset_core.sv
      - pf_reset/hqm_pf_reset_seq.sv
      - src/hqm_clk_gate.sv
      - src/hqm_reset_top.sv
  - target: test
    files:
      - verif/tb_hqm_reset_top.sv
